// File: src/guts_pkg.sv
package guts_pkg;

  // link geometry
  localparam int channel_width_lp  = 8;
  localparam int num_channels_lp   = 2;
  localparam int beat_width_lp     = num_channels_lp * channel_width_lp;
  localparam int flit_width_lp     = 32;
  localparam int beats_per_flit_lp = flit_width_lp / beat_width_lp;

  // each calibration phase lasts calib_max_lp + 1 cycles
  localparam int calib_max_lp       = 32;
  localparam int calib_cnt_width_lp = $clog2(calib_max_lp + 1);

  // router coordinates
  localparam int cord_width_lp     = 4;
  localparam int wh_cord_offset_lp = 4;
  localparam int fsb_data_width_lp = 20;

  // S2 and S3 only time out and drive nothing
  typedef enum logic [2:0] {
    S1, S2, S3, S4, S5, S6, S7, S8
  } calib_state_e;

  // header view of a packet with destid in the top bits
  typedef struct packed {
    logic [cord_width_lp-1:0]     destid;
    logic                         cmd;
    logic [2:0]                   opcode;
    logic [cord_width_lp-1:0]     srcid;
    logic [fsb_data_width_lp-1:0] data;
  } fsb_hdr_s;

  // one packet word, seen raw on the links and as header in the route stage
  typedef union packed {
    logic [flit_width_lp-1:0] raw;
    fsb_hdr_s                 hdr;
  } fsb_pkt_u;

endpackage

// File: src/calib_reset_seq.sv
module calib_reset_seq
  import guts_pkg::*;
(
  input  logic core_clk_i,
  input  logic sync_reset_lo,
  output logic tx_link_reset_o,
  output logic rx_link_reset_o,
  output logic core_reset_o
);

  calib_state_e state_r;
  calib_state_e state_n;

  logic [calib_cnt_width_lp-1:0] cnt_r;
  logic [calib_cnt_width_lp-1:0] cnt_n;

  // one phase step every calib_max_lp + 1 cycles and parks in S8
  always_comb begin
    state_n = state_r;
    cnt_n   = cnt_r;
    if (state_r != S8) begin
      if (cnt_r == calib_cnt_width_lp'(calib_max_lp)) begin
        state_n = calib_state_e'(state_r + 3'd1);
        cnt_n   = '0;
      end else begin
        cnt_n = cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      state_r <= S1;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  // resets are decoded from the next phase, so each one
  // drops on the same edge that enters its phase
  always_ff @(posedge core_clk_i) begin
    if (sync_reset_lo) begin
      tx_link_reset_o <= 1'b1;
      rx_link_reset_o <= 1'b1;
      core_reset_o    <= 1'b1;
    end else begin
      // transmit link comes up first at S5
      tx_link_reset_o <= (state_n < S5);
      // receive link and core together at S8
      rx_link_reset_o <= (state_n != S8);
      core_reset_o    <= (state_n != S8);
    end
  end

  // core must never run with a link still held
  a_core_after_links: assert property (
    @(posedge core_clk_i) disable iff (sync_reset_lo)
    !core_reset_o |-> (!tx_link_reset_o && !rx_link_reset_o)
  ) else $error("core released while a link reset is still high");

endmodule

// File: src/link_rx_deser.sv
module link_rx_deser
  import guts_pkg::*;
(
  input  logic                     core_clk_i,
  input  logic                     link_reset_i,
  input  logic                     io_valid_i,
  input  logic [beat_width_lp-1:0] io_data_i,
  output logic                     flit_v_o,
  output fsb_pkt_u                 flit_data_o
);

  // index of the beat expected next
  logic beat_idx_r;

  // low half waits here for its partner beat
  logic [beat_width_lp-1:0] lo_r;

  logic last_beat;

  assign last_beat = (beat_idx_r == 1'(beats_per_flit_lp - 1));

  // beat count and valid pulse
  always_ff @(posedge core_clk_i) begin
    if (link_reset_i) begin
      beat_idx_r <= 1'b0;
      flit_v_o   <= 1'b0;
    end else begin
      flit_v_o <= io_valid_i && last_beat;
      if (io_valid_i) begin
        beat_idx_r <= beat_idx_r + 1'b1;
      end
    end
  end

  // payload path
  always_ff @(posedge core_clk_i) begin
    if (io_valid_i && !last_beat) begin
      lo_r <= io_data_i;
    end
    if (io_valid_i && last_beat) begin
      // beat 0 is the low half
      flit_data_o.raw <= {io_data_i, lo_r};
    end
  end

  // two beats per packet, so packets can never be adjacent
  a_flit_v_pulse: assert property (
    @(posedge core_clk_i) disable iff (link_reset_i)
    flit_v_o |=> !flit_v_o
  ) else $error("flit_v_o high on two cycles in a row");

endmodule

// File: src/flit_route_stage.sv
module flit_route_stage
  import guts_pkg::*;
(
  input  logic     core_clk_i,
  input  logic     core_reset_i,
  input  logic     flit_v_i,
  input  fsb_pkt_u flit_data_i,
  output logic     route_v_o,
  output fsb_pkt_u route_data_o
);

  fsb_pkt_u routed;

  // destination becomes a router coordinate and wraps within the cord field
  always_comb begin
    routed            = flit_data_i;
    routed.hdr.destid = flit_data_i.hdr.destid + cord_width_lp'(wh_cord_offset_lp);
  end

  always_ff @(posedge core_clk_i) begin
    if (core_reset_i) begin
      route_v_o <= 1'b0;
    end else begin
      route_v_o <= flit_v_i;
    end
  end

  // packet follows the valid with one cycle of latency
  always_ff @(posedge core_clk_i) begin
    if (flit_v_i) begin
      route_data_o <= routed;
    end
  end

endmodule

// File: src/link_tx_ser.sv
module link_tx_ser
  import guts_pkg::*;
(
  input  logic                     core_clk_i,
  input  logic                     link_reset_i,
  input  logic                     route_v_i,
  input  fsb_pkt_u                 route_data_i,
  output logic                     im_valid_o,
  output logic [beat_width_lp-1:0] im_data_o
);

  // high while a beat of the current packet is still to go out
  logic busy_r;

  // next beat to send once busy
  logic beat_idx_r;

  logic [beat_width_lp-1:0] hi_r;

  // control
  always_ff @(posedge core_clk_i) begin
    if (link_reset_i) begin
      busy_r     <= 1'b0;
      beat_idx_r <= 1'b0;
      im_valid_o <= 1'b0;
    end else if (route_v_i) begin
      // beat 0 leaves now and beat 1 is pending
      busy_r     <= 1'b1;
      beat_idx_r <= 1'b1;
      im_valid_o <= 1'b1;
    end else if (busy_r) begin
      busy_r     <= (beat_idx_r != 1'(beats_per_flit_lp - 1));
      beat_idx_r <= beat_idx_r + 1'b1;
      im_valid_o <= 1'b1;
    end else begin
      im_valid_o <= 1'b0;
    end
  end

  // data goes out low half first
  always_ff @(posedge core_clk_i) begin
    if (route_v_i) begin
      im_data_o <= route_data_i.raw[beat_width_lp-1:0];
      hi_r      <= route_data_i.raw[flit_width_lp-1 -: beat_width_lp];
    end else if (busy_r) begin
      im_data_o <= hi_r;
    end
  end

  // without back-pressure the upstream spacing must hold
  a_no_overrun: assert property (
    @(posedge core_clk_i) disable iff (link_reset_i)
    route_v_i |-> !busy_r
  ) else $error("route_v_i arrived while the serializer was busy");

endmodule

// File: src/chip_guts.sv
module chip_guts
  import guts_pkg::*;
(
  input  logic                     core_clk_i,
  input  logic                     sync_reset_lo,
  input  logic                     io_valid_i,
  input  logic [beat_width_lp-1:0] io_data_i,
  output logic                     im_valid_o,
  output logic [beat_width_lp-1:0] im_data_o,
  output logic                     core_reset_o
);

  logic tx_link_reset;
  logic rx_link_reset;

  // deserializer to route stage
  logic     flit_v;
  fsb_pkt_u flit_data;

  // route stage to serializer
  logic     route_v;
  fsb_pkt_u route_data;

  calib_reset_seq u_calib_reset_seq (
    .core_clk_i      (core_clk_i),
    .sync_reset_lo   (sync_reset_lo),
    .tx_link_reset_o (tx_link_reset),
    .rx_link_reset_o (rx_link_reset),
    .core_reset_o    (core_reset_o)
  );

  link_rx_deser u_link_rx_deser (
    .core_clk_i   (core_clk_i),
    .link_reset_i (rx_link_reset),
    .io_valid_i   (io_valid_i),
    .io_data_i    (io_data_i),
    .flit_v_o     (flit_v),
    .flit_data_o  (flit_data)
  );

  // core reset from calibration also holds the route stage
  flit_route_stage u_flit_route_stage (
    .core_clk_i   (core_clk_i),
    .core_reset_i (core_reset_o),
    .flit_v_i     (flit_v),
    .flit_data_i  (flit_data),
    .route_v_o    (route_v),
    .route_data_o (route_data)
  );

  link_tx_ser u_link_tx_ser (
    .core_clk_i   (core_clk_i),
    .link_reset_i (tx_link_reset),
    .route_v_i    (route_v),
    .route_data_i (route_data),
    .im_valid_o   (im_valid_o),
    .im_data_o    (im_data_o)
  );

endmodule

// File: dv/tb_chip_guts.sv
module tb_chip_guts
  import guts_pkg::*;
();

  localparam int num_pkts_lp    = 30;
  // packets before this index go back to back, the rest with random gaps
  localparam int first_gap_lp   = 15;
  // seven phase steps of calib_max_lp + 1 cycles until S8
  localparam int calib_edges_lp = 7 * (calib_max_lp + 1);
  localparam int settle_lp      = 12;
  localparam int drain_limit_lp = 200;

  logic                     core_clk_i;
  logic                     sync_reset_lo;
  logic                     io_valid_i;
  logic [beat_width_lp-1:0] io_data_i;
  logic                     im_valid_o;
  logic [beat_width_lp-1:0] im_data_o;
  logic                     core_reset_o;

  // even entries hold input packets, odd entries the expected output
  logic [flit_width_lp-1:0] stim_mem [0:2*num_pkts_lp-1];

  integer seed;
  int     cyc = 0;
  string  test_name;
  logic   mon_en = 1'b0;

  fsb_pkt_u exp_q[$];
  int       lat_q[$];

  // output monitor state
  logic                     have_lo = 1'b0;
  logic [beat_width_lp-1:0] lo_beat;
  int                       first_cyc;
  int                       n_out = 0;
  fsb_pkt_u                 got_pkt;

  chip_guts u_dut (
    .core_clk_i    (core_clk_i),
    .sync_reset_lo (sync_reset_lo),
    .io_valid_i    (io_valid_i),
    .io_data_i     (io_data_i),
    .im_valid_o    (im_valid_o),
    .im_data_o     (im_data_o),
    .core_reset_o  (core_reset_o)
  );

  always #5 core_clk_i = ~core_clk_i;

  always @(posedge core_clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flit(input fsb_pkt_u exp, input fsb_pkt_u act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error %s: expected %h actual %h (destid %0d vs %0d)",
                              test_name, exp.raw, act.raw, exp.hdr.destid, act.hdr.destid));
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error %s: expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_on_error($sformatf("Error %s: expected cycle %0d actual cycle %0d",
                              name, exp, act));
    end
  endtask

  // carry out of the top field drops off, which gives the wrap at 16
  function automatic fsb_pkt_u expected_route(input logic [flit_width_lp-1:0] word);
    fsb_pkt_u pkt;
    pkt.raw = word + (flit_width_lp'(wh_cord_offset_lp) << (flit_width_lp - cord_width_lp));
    return pkt;
  endfunction

  task automatic drive_beat(input logic [beat_width_lp-1:0] beat);
    @(negedge core_clk_i);
    check_level("core stays up", 1'b0, core_reset_o);
    io_valid_i = 1'b1;
    io_data_i  = beat;
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(negedge core_clk_i);
      io_valid_i = 1'b0;
    end
  endtask

  task automatic send_packet(input int idx, input int gap);
    fsb_pkt_u pkt;
    fsb_pkt_u exp;
    pkt.raw = stim_mem[2*idx];
    exp.raw = stim_mem[2*idx+1];
    drive_idle(gap);
    // beat 0 is the low half
    drive_beat(pkt.raw[beat_width_lp-1:0]);
    drive_beat(pkt.raw[flit_width_lp-1 -: beat_width_lp]);
    exp_q.push_back(exp);
    // first output beat 3 cycles after the cycle holding the last input beat
    lat_q.push_back(cyc + 3);
  endtask

  task automatic wait_drain();
    int i;
    for (i = 0; i < drain_limit_lp && exp_q.size() != 0; i++) begin
      @(posedge core_clk_i);
    end
    if (exp_q.size() != 0) begin
      stop_on_error($sformatf("%0d output packets never came out in test %s",
                              exp_q.size(), test_name));
    end
  endtask

  task automatic apply_reset(input string name);
    @(negedge core_clk_i);
    sync_reset_lo = 1'b1;
    io_valid_i    = 1'b0;
    repeat (2) @(negedge core_clk_i);
    check_level({name, " core in reset"}, 1'b1, core_reset_o);
    check_level({name, " output silenced"}, 1'b0, im_valid_o);
    sync_reset_lo = 1'b0;
  endtask

  // k counts edges since reset went low, core comes up on edge 231
  task automatic check_calibration(input string name);
    int     k;
    integer rnd;
    for (k = 1; k <= calib_edges_lp + settle_lp; k++) begin
      @(negedge core_clk_i);
      if (k < calib_edges_lp) begin
        check_level({name, " core held"}, 1'b1, core_reset_o);
      end else begin
        check_level({name, " core released"}, 1'b0, core_reset_o);
      end
      check_level({name, " output quiet"}, 1'b0, im_valid_o);
      // junk beats while the receive link is still held
      rnd        = $random(seed);
      io_valid_i = (k >= 40 && k < 220) ? rnd[0] : 1'b0;
      io_data_i  = rnd[beat_width_lp:1];
    end
  endtask

  // pairs output beats back into packets
  always @(negedge core_clk_i) begin
    if (!mon_en) begin
      have_lo = 1'b0;
    end else if (im_valid_o === 1'b1) begin
      if (!have_lo) begin
        lo_beat   = im_data_o;
        first_cyc = cyc;
        have_lo   = 1'b1;
      end else begin
        have_lo     = 1'b0;
        got_pkt.raw = {im_data_o, lo_beat};
        if (exp_q.size() == 0) begin
          stop_on_error("an output packet came out when none was expected");
        end
        check_flit(exp_q.pop_front(), got_pkt);
        check_cycle({test_name, " latency"}, lat_q.pop_front(), first_cyc);
        n_out = n_out + 1;
      end
    end else if (im_valid_o !== 1'b0) begin
      stop_on_error("im_valid_o is unknown after calibration");
    end else if (have_lo) begin
      stop_on_error("the second beat of an output packet never came");
    end
  end

  initial begin
    int       i;
    integer   rnd;
    fsb_pkt_u file_exp;
    core_clk_i    = 1'b1;
    sync_reset_lo = 1'b1;
    io_valid_i    = 1'b0;
    io_data_i     = '0;
    seed          = 32'h70b2;

    // fill tied to the address, a short file then fails the file check
    for (i = 0; i < 2 * num_pkts_lp; i++) begin
      stim_mem[i] = 32'hdead_0000 ^ i;
    end
    $readmemh("dv/flit_input.mem", stim_mem);
    test_name = "file_check";
    for (i = 0; i < num_pkts_lp; i++) begin
      file_exp.raw = stim_mem[2*i+1];
      check_flit(expected_route(stim_mem[2*i]), file_exp);
    end

    test_name = "calib_first";
    apply_reset(test_name);
    check_calibration(test_name);
    @(posedge core_clk_i);
    mon_en = 1'b1;

    test_name = "back_to_back";
    for (i = 0; i < first_gap_lp; i++) begin
      send_packet(i, 0);
    end
    drive_idle(1);
    wait_drain();

    test_name = "random_gaps";
    for (i = first_gap_lp; i < num_pkts_lp; i++) begin
      rnd = $random(seed);
      send_packet(i, int'(rnd[1:0]));
    end
    drive_idle(1);
    wait_drain();

    // reset while two packets and half of a third are in flight
    test_name = "mid_reset";
    send_packet(1, 0);
    send_packet(2, 0);
    drive_beat(stim_mem[6][beat_width_lp-1:0]);
    @(posedge core_clk_i);
    mon_en = 1'b0;
    exp_q.delete();
    lat_q.delete();
    apply_reset(test_name);
    check_calibration("calib_second");
    @(posedge core_clk_i);
    mon_en = 1'b1;

    test_name = "after_reset";
    send_packet(0, 2);
    drive_idle(1);
    wait_drain();

    if (n_out != num_pkts_lp + 1) begin
      stop_on_error($sformatf("%0d packets came out but %0d were expected",
                              n_out, num_pkts_lp + 1));
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// File: project.f
src/guts_pkg.sv
src/calib_reset_seq.sv
src/link_rx_deser.sv
src/flit_route_stage.sv
src/link_tx_ser.sv
src/chip_guts.sv
dv/tb_chip_guts.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_chip_guts
RTL_TOP   ?= chip_guts
SEED_FILE ?= dv/flit_input.mem
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the simulator exits non-zero on any $fatal, which fails this target
sim: $(SEED_FILE)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/flit_input.mem
// column 1: input packet, column 2: expected output packet
// destid is the top hex digit, the output moves it up by 4 and wraps at 16
0123abcd 4123abcd
1a2b3c4d 5a2b3c4d
2f00e011 6f00e011
3c5a0000 7c5a0000
40000001 80000001
5555aaaa 9555aaaa
6789fedc a789fedc
7fffffff bfffffff
8badf00d cbadf00d
9e37779b de37779b
a5a55a5a e5a55a5a
b0c0ffee f0c0ffee
c0ffee12 00ffee12
d1e2f304 11e2f304
e8765432 28765432
f0000000 30000000
ffff0000 3fff0000
c3c33c3c 03c33c3c
dead1234 1ead1234
e0e01f1f 20e01f1f
f1234567 31234567
12345678 52345678
87654321 c7654321
00ff00ff 40ff00ff
6c6d6e6f ac6d6e6f
3a3b7c7d 7a3b7c7d
b1b2c1c2 f1b2c1c2
cafe0bad 0afe0bad
9abcdef0 dabcdef0
ef01ab23 2f01ab23
